/* logic/vsaIsaPkg.sv */
// ISA of the 16-bit core; R0 reads zero, 12-bit PC, opcode 6 and unknown func codes are no-ops
package vsaIsaPkg;

    typedef logic [15:0] instrWord;   // one instruction word
    typedef logic [15:0] dataWord;    // register or memory value
    typedef logic [11:0] pcAddr;      // byte address, bit 0 always 0
    typedef logic [1:0]  regIdx;      // R0..R3
    typedef logic [8:0]  immField;    // I-format immediate, signed

    // major opcode, top three bits of the word
    typedef enum logic [2:0] {
        LW    = 3'd0,
        SW    = 3'd1,
        BEQZ  = 3'd2,
        ALUOP = 3'd3,   // R-format, func selects the operation
        ADDI  = 3'd4,
        SUBI  = 3'd5,
        HALT  = 3'd7    // stops the core until the next start
    } opcodeE;

    // R-format function field
    typedef enum logic [6:0] {
        ADD = 7'd0,
        SUB = 7'd1,
        AND = 7'd2,
        OR  = 7'd3,
        XOR = 7'd4,
        SRL = 7'd5      // logical shift right by one
    } funcE;

    // R-format: opcode, src1, src2, dest, func
    typedef struct packed {
        opcodeE op;
        regIdx  rs1;
        regIdx  rs2;
        regIdx  rd;
        funcE   func;
    } rInstr;

    // I-format: opcode, src1, dest, immediate
    typedef struct packed {
        opcodeE  op;
        regIdx   rs1;
        regIdx   rd;     // also the store data source for SW
        immField imm;
    } iInstr;

    // core FSM, IF..WB is the classic five-step sequence
    typedef enum logic [2:0] {
        IDLE,
        IF,
        ID,
        EX,
        MEM,
        WB,
        HALTED
    } coreStateE;

endpackage

/* logic/vsaBusPkg.sv */
// memory and host bus types; one request in flight per requester, host map has memory below 0x8000
package vsaBusPkg;

    localparam int memDepth = 2048;   // halfwords in the unified memory

    typedef logic [$clog2(memDepth)-1:0] memIdx;   // word address
    typedef logic [15:0] apbAddr;                  // host byte address

    // internal request, held until ready is seen
    typedef struct packed {
        logic              valid;
        logic              write;
        memIdx             addr;
        vsaIsaPkg::dataWord wdata;
    } memReq;

    // ready pulses one cycle, rdata valid with it on reads
    typedef struct packed {
        logic              ready;
        vsaIsaPkg::dataWord rdata;
    } memRsp;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        apbAddr            paddr;
        vsaIsaPkg::dataWord pwdata;
    } apbReq;

    typedef struct packed {
        logic              pready;
        vsaIsaPkg::dataWord prdata;
        logic              pslverr;
    } apbRsp;

    // host address map
    localparam apbAddr ctrlBase       = 16'h8000;   // first control address
    localparam apbAddr ctrlRunAddr    = 16'h8000;   // write bit 0 = 1 to start
    localparam apbAddr ctrlStatusAddr = 16'h8002;   // bit 0 halted, bit 1 running

endpackage

/* logic/vsaCore.sv */
// multicycle core; fetch and LW/SW wait on memory ready, HALT parks the core until start
module vsaCore (
    input  logic              clock,
    input  logic              rstN,
    input  logic              start,     // one-cycle pulse from host
    output vsaBusPkg::memReq  memReqO,
    input  vsaBusPkg::memRsp  memRspI,
    output logic              halted,
    output logic              running
);

    vsaIsaPkg::coreStateE state;
    vsaIsaPkg::pcAddr     pc;
    vsaIsaPkg::pcAddr     npc;        // pc + 2, captured in IF
    vsaIsaPkg::instrWord  ir;
    vsaIsaPkg::dataWord   a;          // first ALU operand
    vsaIsaPkg::dataWord   b;          // second operand, also store data
    vsaIsaPkg::dataWord   aluOut;     // result or memory / branch address
    vsaIsaPkg::dataWord   lmd;        // load data
    logic                 cond;       // BEQZ taken
    logic                 wbEn;       // WB writes the register file
    vsaIsaPkg::dataWord   regFile [4];

    vsaIsaPkg::rInstr     rFmt;
    vsaIsaPkg::iInstr     iFmt;
    vsaIsaPkg::dataWord   immExt;
    vsaIsaPkg::dataWord   aluNext;
    logic                 condNext;
    logic                 wbNext;
    logic                 memRef;     // LW or SW
    vsaIsaPkg::regIdx     wbIdx;
    vsaIsaPkg::dataWord   wbData;

    // same word seen through both formats
    assign rFmt = vsaIsaPkg::rInstr'(ir);
    assign iFmt = vsaIsaPkg::iInstr'(ir);
    assign immExt = {{7{iFmt.imm[8]}}, iFmt.imm};   // sign from bit 8
    assign memRef = (rFmt.op == vsaIsaPkg::LW) || (rFmt.op == vsaIsaPkg::SW);

    assign halted = (state == vsaIsaPkg::HALTED);
    assign running = (state != vsaIsaPkg::IDLE) && (state != vsaIsaPkg::HALTED);

    // ALU and write-back decision, registered in EX
    always_comb begin
        aluNext = aluOut;
        condNext = 1'b0;
        wbNext = 1'b0;
        case (rFmt.op)
            vsaIsaPkg::LW: begin
                aluNext = a + immExt;
                wbNext = 1'b1;
            end
            vsaIsaPkg::SW: aluNext = a + immExt;
            vsaIsaPkg::BEQZ: begin
                aluNext = {4'd0, npc} + {immExt[14:0], 1'b0};   // word offset
                condNext = (a == '0);
            end
            vsaIsaPkg::ALUOP: begin
                wbNext = 1'b1;
                case (rFmt.func)
                    vsaIsaPkg::ADD: aluNext = a + b;
                    vsaIsaPkg::SUB: aluNext = a - b;
                    vsaIsaPkg::AND: aluNext = a & b;
                    vsaIsaPkg::OR:  aluNext = a | b;
                    vsaIsaPkg::XOR: aluNext = a ^ b;
                    vsaIsaPkg::SRL: aluNext = {1'b0, a[15:1]};
                    default:        wbNext = 1'b0;   // unknown func is a no-op
                endcase
            end
            vsaIsaPkg::ADDI: begin
                aluNext = a + immExt;
                wbNext = 1'b1;
            end
            vsaIsaPkg::SUBI: begin
                aluNext = a - immExt;
                wbNext = 1'b1;
            end
            default: ;   // opcode 6 and HALT change nothing here
        endcase
    end

    // R-format writes rd, I-format writes the second field
    assign wbIdx = (rFmt.op == vsaIsaPkg::ALUOP) ? rFmt.rd : iFmt.rd;
    assign wbData = (rFmt.op == vsaIsaPkg::LW) ? lmd : aluOut;

    // fetch in IF, data access in MEM for LW/SW only
    always_comb begin
        memReqO = '0;
        if (state == vsaIsaPkg::IF) begin
            memReqO.valid = 1'b1;
            memReqO.addr = pc[11:1];
        end else if (state == vsaIsaPkg::MEM && memRef) begin
            memReqO.valid = 1'b1;
            memReqO.write = (rFmt.op == vsaIsaPkg::SW);
            memReqO.addr = aluOut[11:1];
            memReqO.wdata = b;
        end
    end

    // control state and register file
    always_ff @(posedge clock) begin
        if (!rstN) begin
            state <= vsaIsaPkg::IDLE;
            pc <= '0;
            wbEn <= 1'b0;
            regFile <= '{default: '0};
        end else begin
            case (state)
                vsaIsaPkg::IDLE, vsaIsaPkg::HALTED: begin
                    if (start) begin
                        pc <= '0;   // registers keep their values
                        state <= vsaIsaPkg::IF;
                    end
                end
                vsaIsaPkg::IF: begin
                    if (memRspI.ready) state <= vsaIsaPkg::ID;
                end
                vsaIsaPkg::ID: state <= vsaIsaPkg::EX;
                vsaIsaPkg::EX: begin
                    wbEn <= wbNext;
                    if (rFmt.op == vsaIsaPkg::HALT) state <= vsaIsaPkg::HALTED;
                    else state <= vsaIsaPkg::MEM;
                end
                vsaIsaPkg::MEM: begin
                    if (!memRef || memRspI.ready) begin   // stall on LW/SW
                        if (rFmt.op == vsaIsaPkg::BEQZ && cond) pc <= aluOut[11:0];
                        else pc <= npc;
                        state <= vsaIsaPkg::WB;
                    end
                end
                vsaIsaPkg::WB: begin
                    if (wbEn && wbIdx != 2'd0) regFile[wbIdx] <= wbData;   // R0 stays 0
                    state <= vsaIsaPkg::IF;
                end
                default: state <= vsaIsaPkg::IDLE;
            endcase
        end
    end

    // datapath registers
    always_ff @(posedge clock) begin
        if (state == vsaIsaPkg::IF && memRspI.ready) begin
            ir <= memRspI.rdata;
            npc <= pc + 12'd2;
        end
        if (state == vsaIsaPkg::ID) begin
            a <= regFile[rFmt.rs1];
            b <= regFile[rFmt.rs2];   // rs2 and I-format dest share bits
        end
        if (state == vsaIsaPkg::EX) begin
            aluOut <= aluNext;
            cond <= condNext;
        end
        if (state == vsaIsaPkg::MEM && memRspI.ready) lmd <= memRspI.rdata;
    end

endmodule

/* logic/memArbiter.sv */
// two-requester round-robin arbiter; one access in flight, each occupies the RAM for two cycles
module memArbiter (
    input  logic             clock,
    input  logic             rstN,
    input  vsaBusPkg::memReq coreReq,
    output vsaBusPkg::memRsp coreRsp,
    input  vsaBusPkg::memReq hostReq,
    output vsaBusPkg::memRsp hostRsp,
    output vsaBusPkg::memReq ramReq,
    input  vsaBusPkg::memRsp ramRsp
);

    typedef enum logic {
        IDLE,
        BUSY     // waiting for RAM ready
    } arbStateE;

    arbStateE state;
    logic     lastHost;   // last grant, and the owner while busy
    logic     anyValid;
    logic     pickHost;

    assign anyValid = coreReq.valid || hostReq.valid;
    // host wins when alone or when the core had the last turn
    assign pickHost = hostReq.valid && (!coreReq.valid || !lastHost);

    // forward the winner for the single idle cycle
    always_comb begin
        ramReq = pickHost ? hostReq : coreReq;
        ramReq.valid = (state == IDLE) && anyValid;
    end

    // response only to the owner
    always_comb begin
        coreRsp = '0;
        hostRsp = '0;
        if (state == BUSY) begin
            if (lastHost) hostRsp = ramRsp;
            else coreRsp = ramRsp;
        end
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            state <= IDLE;
            lastHost <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (anyValid) begin
                        lastHost <= pickHost;
                        state <= BUSY;
                    end
                end
                BUSY: begin
                    if (ramRsp.ready) state <= IDLE;   // requester drops valid next
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* logic/sharedRam.sv */
// single-port halfword RAM; contents not reset, ready one cycle after each valid request
module sharedRam (
    input  logic             clock,
    input  logic             rstN,
    input  vsaBusPkg::memReq req,
    output vsaBusPkg::memRsp rsp
);

    vsaIsaPkg::dataWord mem [vsaBusPkg::memDepth];
    vsaIsaPkg::dataWord rdata;   // last read, held across writes
    logic               ready;

    // array and read register
    always_ff @(posedge clock) begin
        if (req.valid) begin
            if (req.write) begin
                mem[req.addr] <= req.wdata;
            end else begin
                rdata <= mem[req.addr];
            end
        end
    end

    // one-cycle ready pulse per accepted request
    always_ff @(posedge clock) begin
        if (!rstN) begin
            ready <= 1'b0;
        end else begin
            ready <= req.valid;
        end
    end

    assign rsp.ready = ready;
    assign rsp.rdata = rdata;

endmodule

/* logic/apbHostPort.sv */
// APB slave; paddr bits 14..12 alias in memory space, start is a pulse one cycle after the write
module apbHostPort (
    input  logic             clock,
    input  logic             rstN,
    input  vsaBusPkg::apbReq apbI,
    output vsaBusPkg::apbRsp apbO,
    output vsaBusPkg::memReq memReqO,
    input  vsaBusPkg::memRsp memRspI,
    output logic             start,
    input  logic             halted,
    input  logic             running
);

    logic               access;      // APB access phase
    logic               isCtrl;      // paddr bit 15 set
    logic               runHit;
    logic               statHit;
    logic               xferDone;    // memory transfer already answered
    vsaIsaPkg::dataWord statusReg;

    assign access = apbI.psel && apbI.penable;
    assign isCtrl = (apbI.paddr >= vsaBusPkg::ctrlBase);
    assign runHit = (apbI.paddr == vsaBusPkg::ctrlRunAddr);
    assign statHit = (apbI.paddr == vsaBusPkg::ctrlStatusAddr);

    // one request per transfer, held until ready
    always_comb begin
        memReqO.valid = access && !isCtrl && !xferDone;
        memReqO.write = apbI.pwrite;
        memReqO.addr = apbI.paddr[11:1];   // byte to word address
        memReqO.wdata = apbI.pwdata;
    end

    always_comb begin
        apbO = '0;
        if (access && isCtrl) begin
            apbO.pready = 1'b1;   // control answers at once
            apbO.pslverr = !(runHit || statHit);
            if (statHit && !apbI.pwrite) apbO.prdata = statusReg;
        end else if (access) begin
            apbO.pready = memRspI.ready;
            if (!apbI.pwrite) apbO.prdata = memRspI.rdata;
        end
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            start <= 1'b0;
            xferDone <= 1'b0;
            statusReg <= '0;
        end else begin
            start <= access && runHit && apbI.pwrite && apbI.pwdata[0];
            statusReg <= {14'd0, running, halted};
            // stays set if the master lingers in the access phase
            if (!access) xferDone <= 1'b0;
            else if (!isCtrl && memRspI.ready) xferDone <= 1'b1;
        end
    end

endmodule

/* logic/vsaTop.sv */
// core plus host port sharing one RAM; host APB is the only external bus
module vsaTop (
    input  logic             clock,
    input  logic             rstN,
    input  vsaBusPkg::apbReq apbI,
    output vsaBusPkg::apbRsp apbO,
    output logic             halted,
    output logic             running
);

    vsaBusPkg::memReq coreReq;
    vsaBusPkg::memRsp coreRsp;
    vsaBusPkg::memReq hostReq;
    vsaBusPkg::memRsp hostRsp;
    vsaBusPkg::memReq ramReq;
    vsaBusPkg::memRsp ramRsp;
    logic             start;     // host run bit pulse

    vsaCore core (
        .clock   (clock),
        .rstN    (rstN),
        .start   (start),
        .memReqO (coreReq),
        .memRspI (coreRsp),
        .halted  (halted),
        .running (running)
    );

    apbHostPort host (
        .clock   (clock),
        .rstN    (rstN),
        .apbI    (apbI),
        .apbO    (apbO),
        .memReqO (hostReq),
        .memRspI (hostRsp),
        .start   (start),
        .halted  (halted),
        .running (running)
    );

    memArbiter arb (
        .clock   (clock),
        .rstN    (rstN),
        .coreReq (coreReq),
        .coreRsp (coreRsp),
        .hostReq (hostReq),
        .hostRsp (hostRsp),
        .ramReq  (ramReq),
        .ramRsp  (ramRsp)
    );

    sharedRam ram (
        .clock (clock),
        .rstN  (rstN),
        .req   (ramReq),
        .rsp   (ramRsp)
    );

endmodule

/* tb/tbClock.sv */
// 100 ns clock from time 0; rstN low for three rising edges, released on a falling edge
module tbClock (
    output logic clock,
    output logic rstN
);
    timeunit 1ns;
    timeprecision 1ns;

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;   // 100 ns period
    end

    initial begin
        rstN = 1'b0;
        repeat (3) @(posedge clock);
        @(negedge clock);   // release away from the active edge
        rstN = 1'b1;
    end

endmodule

/* tb/vsaTb.sv */
// directed tests of vsaTop over APB; programs load at byte 0, test data sits at bytes 0xC0..0xFA
module vsaTb;
    timeunit 1ns;
    timeprecision 1ns;

    // opcode and func encodings of the ISA
    localparam logic [2:0] opLw = 3'd0;
    localparam logic [2:0] opSw = 3'd1;
    localparam logic [2:0] opBeqz = 3'd2;
    localparam logic [2:0] opAlu = 3'd3;
    localparam logic [2:0] opAddi = 3'd4;
    localparam logic [2:0] opSubi = 3'd5;
    localparam logic [2:0] opHalt = 3'd7;
    localparam logic [15:0] runAddr = 16'h8000;
    localparam logic [15:0] statusAddr = 16'h8002;
    localparam logic [15:0] badAddr = 16'h8004;   // unmapped control word
    localparam int readyLimit = 50;                 // cycles per APB access phase
    localparam int pollLimit = 20000;               // status polls per program

    logic clock;
    logic rstN;
    vsaBusPkg::apbReq apbI;
    vsaBusPkg::apbRsp apbO;
    logic halted;
    logic running;

    logic [31:0] seed;
    logic [15:0] prog [$];        // program image, word 0 at byte 0
    logic [15:0] hostAddr [8];    // test 1 words, reread under contention
    logic [15:0] hostData [8];
    int errors;
    int checks;
    int testsRun;
    int testsFailed;
    int errorsAtStart;

    tbClock clkGen (
        .clock (clock),
        .rstN  (rstN)
    );

    vsaTop dut (
        .clock   (clock),
        .rstN    (rstN),
        .apbI    (apbI),
        .apbO    (apbO),
        .halted  (halted),
        .running (running)
    );

    function automatic logic [15:0] lcgNext();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[30:15];   // upper bits, low ones cycle fast
    endfunction

    // R-format: op, rs1, rs2, rd, func
    function automatic logic [15:0] rType(int fn, int rs1, int rs2, int rd);
        return {opAlu, 2'(rs1), 2'(rs2), 2'(rd), 7'(fn)};
    endfunction

    // I-format: op, rs1, rd, 9-bit two's complement immediate
    function automatic logic [15:0] iType(logic [2:0] op, int rs1, int rd, int imm);
        return {op, 2'(rs1), 2'(rd), 9'(imm)};
    endfunction

    task automatic checkEq(input logic [15:0] got, input logic [15:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s, got %h expected %h", $time, msg, got, exp);
            errors++;
        end
    endtask

    // one APB transfer, setup then access until pready
    task automatic apbXfer(input logic wr, input logic [15:0] addr, input logic [15:0] wdata,
                           output logic [15:0] rdata, output logic err);
        int waitCnt;
        waitCnt = 0;
        @(negedge clock);
        apbI.psel = 1'b1;
        apbI.penable = 1'b0;
        apbI.pwrite = wr;
        apbI.paddr = addr;
        apbI.pwdata = wdata;
        @(negedge clock);
        apbI.penable = 1'b1;
        #1;   // let the slave's combinational response settle
        while (!apbO.pready && waitCnt < readyLimit) begin
            @(negedge clock);
            #1;
            waitCnt++;
        end
        if (!apbO.pready) begin
            $display("timeout: no pready for APB access to address %h", addr);
            errors++;
        end
        rdata = apbO.prdata;
        err = apbO.pslverr;
        @(negedge clock);   // transfer completed on the rising edge just passed
        apbI = '0;
    endtask

    task automatic apbWrite(input logic [15:0] addr, input logic [15:0] data);
        logic [15:0] unusedRd;
        logic err;
        apbXfer(1'b1, addr, data, unusedRd, err);
        checkEq({15'd0, err}, 16'd0, $sformatf("pslverr on write to %h", addr));
    endtask

    task automatic apbRead(input logic [15:0] addr, output logic [15:0] data, output logic err);
        apbXfer(1'b0, addr, 16'd0, data, err);
    endtask

    task automatic readCheck(input logic [15:0] addr, input logic [15:0] exp, input string msg);
        logic [15:0] rd;
        logic err;
        apbRead(addr, rd, err);
        checkEq(rd, exp, msg);
    endtask

    task automatic loadProgram();
        foreach (prog[i]) begin
            apbWrite(16'(i * 2), prog[i]);
        end
    endtask

    // polls status until running was seen and then halted alone
    task automatic waitHalt();
        logic [15:0] st;
        logic err;
        logic sawRun;
        int polls;
        st = '0;
        sawRun = 1'b0;
        polls = 0;
        while (!(sawRun && st[1:0] == 2'b01) && polls < pollLimit) begin
            apbRead(statusAddr, st, err);
            if (st[1]) sawRun = 1'b1;   // first read after start can be stale
            polls++;
        end
        if (!(sawRun && st[1:0] == 2'b01)) begin
            $display("timeout: core never reported running then halted");
            errors++;
        end
    endtask

    task automatic runProgram();
        loadProgram();
        apbWrite(runAddr, 16'h0001);
        waitHalt();
    endtask

    task automatic testDone(input string name);
        testsRun++;
        if (errors == errorsAtStart) begin
            $display("test %s finished, no errors", name);
        end else begin
            testsFailed++;
            $display("test %s finished, %0d errors", name, errors - errorsAtStart);
        end
        errorsAtStart = errors;
    endtask

    // n from src, loop count stored to dst; seven words
    task automatic pushCountdown(input int src, input int dst);
        prog.push_back(iType(opLw, 0, 1, src));       // R1 = n
        prog.push_back(iType(opAddi, 0, 2, 0));       // R2 = 0
        prog.push_back(iType(opBeqz, 1, 0, 3));       // exit to word 6
        prog.push_back(iType(opSubi, 1, 1, 1));
        prog.push_back(iType(opAddi, 2, 2, 1));
        prog.push_back(iType(opBeqz, 0, 0, -4));      // always back to word 2
        prog.push_back(iType(opSw, 0, 2, dst));
    endtask

    task automatic hostMemTest();
        logic [15:0] r;
        logic [15:0] rd;
        logic err;
        checkEq({14'd0, running, halted}, 16'h0000, "core outputs before any start");
        readCheck(statusAddr, 16'h0000, "status before any start");
        for (int i = 0; i < 8; i++) begin
            r = lcgNext();
            // low nibble from i keeps the eight addresses distinct
            hostAddr[i] = 16'h0800 + {5'd0, r[6:0], 4'h0} + 16'(i * 2);
            hostData[i] = lcgNext();
            apbWrite(hostAddr[i], hostData[i]);
        end
        for (int i = 0; i < 8; i++) begin
            readCheck(hostAddr[i], hostData[i], $sformatf("readback of %h", hostAddr[i]));
        end
        apbRead(badAddr, rd, err);
        checkEq({15'd0, err}, 16'd1, "pslverr on unmapped control read");
        testDone("hostMem");
    endtask

    task automatic aluTest();
        logic [15:0] opA;
        logic [15:0] opB;
        int fns [8];
        int src2 [8];
        logic [15:0] expv [8];
        opA = lcgNext();
        opB = lcgNext();
        fns = '{0, 1, 2, 3, 4, 5, 4, 1};   // add sub and or xor srl, then a^a and a-a
        src2 = '{2, 2, 2, 2, 2, 2, 1, 1};
        expv = '{opA + opB, opA - opB, opA & opB, opA | opB, opA ^ opB, opA >> 1, 16'd0, 16'd0};
        apbWrite(16'h00C0, opA);
        apbWrite(16'h00C2, opB);
        for (int k = 0; k < 8; k++) begin
            apbWrite(16'(196 + 2 * k), ~expv[k]);   // result slots start as the inverse
        end
        prog.delete();
        prog.push_back(iType(opLw, 0, 1, 'hC0));
        prog.push_back(iType(opLw, 0, 2, 'hC2));
        for (int k = 0; k < 8; k++) begin
            prog.push_back(rType(fns[k], 1, src2[k], 3));
            prog.push_back(iType(opSw, 0, 3, 'hC4 + 2 * k));
        end
        prog.push_back({opHalt, 13'd0});
        runProgram();
        for (int k = 0; k < 8; k++) begin
            readCheck(16'(196 + 2 * k), expv[k], $sformatf("alu result %0d", k));
        end
        testDone("alu");
    endtask

    task automatic immTest();
        int pos;
        int neg;
        pos = int'(lcgNext() % 16'd200) + 1;
        neg = -(int'(lcgNext() % 16'd200) + 1);
        apbWrite(16'h00E8, 16'hA5A5);   // must be overwritten by the R0 store
        prog.delete();
        prog.push_back(iType(opAddi, 0, 1, pos));
        prog.push_back(iType(opSw, 0, 1, 'hE0));
        prog.push_back(iType(opAddi, 0, 2, neg));
        prog.push_back(iType(opSw, 0, 2, 'hE2));
        prog.push_back(iType(opSubi, 1, 3, neg));
        prog.push_back(iType(opSw, 0, 3, 'hE4));
        prog.push_back(iType(opSubi, 2, 3, pos));
        prog.push_back(iType(opSw, 0, 3, 'hE6));
        prog.push_back(iType(opAddi, 1, 0, 5));       // targets R0
        prog.push_back(iType(opSw, 0, 0, 'hE8));
        prog.push_back({opHalt, 13'd0});
        runProgram();
        readCheck(16'h00E0, 16'(pos), "addi positive");
        readCheck(16'h00E2, 16'(neg), "addi negative");
        readCheck(16'h00E4, 16'(pos - neg), "subi negative imm");
        readCheck(16'h00E6, 16'(neg - pos), "subi positive imm");
        readCheck(16'h00E8, 16'h0000, "store of R0 after write to R0");
        testDone("immediate");
    endtask

    task automatic branchTest();
        int n;
        n = int'(lcgNext() % 16'd12) + 1;
        apbWrite(16'h00F0, 16'(n));
        prog.delete();
        pushCountdown('hF0, 'hF2);
        prog.push_back(iType(opAddi, 0, 3, 1));       // R3 = 1, branch below not taken
        prog.push_back(iType(opBeqz, 3, 0, 1));
        prog.push_back(iType(opAddi, 0, 3, 7));       // reached only on fall through
        prog.push_back(iType(opSw, 0, 3, 'hF4));
        prog.push_back({opHalt, 13'd0});
        runProgram();
        readCheck(16'h00F2, 16'(n), "countdown iterations");
        readCheck(16'h00F4, 16'h0007, "not-taken beqz fall through");
        testDone("branch");
    endtask

    task automatic contentionTest();
        int n;
        int n2;
        n = int'(lcgNext() % 16'd40) + 60;   // long enough to overlap host reads
        n2 = int'(lcgNext() % 16'd20) + 1;
        apbWrite(16'h00F8, 16'(n));
        apbWrite(16'h00FA, 16'h0000);
        prog.delete();
        pushCountdown('hF8, 'hFA);
        prog.push_back({opHalt, 13'd0});
        loadProgram();
        apbWrite(runAddr, 16'h0001);
        for (int round = 0; round < 2; round++) begin
            for (int i = 0; i < 8; i++) begin
                readCheck(hostAddr[i], hostData[i], $sformatf("read under load %h", hostAddr[i]));
            end
        end
        readCheck(statusAddr, 16'h0002, "status while running");
        checkEq({14'd0, running, halted}, 16'h0002, "core outputs while running");
        waitHalt();
        readCheck(16'h00FA, 16'(n), "loop count under contention");
        // rerun from PC 0 with a new count
        apbWrite(16'h00F8, 16'(n2));
        apbWrite(runAddr, 16'h0001);
        waitHalt();
        readCheck(16'h00FA, 16'(n2), "loop count after restart");
        readCheck(statusAddr, 16'h0001, "status after halt");
        checkEq({14'd0, running, halted}, 16'h0001, "core outputs after halt");
        testDone("contention");
    endtask

    initial begin
        int waitCnt;
        apbI = '0;
        seed = 32'd93022;
        errors = 0;
        checks = 0;
        testsRun = 0;
        testsFailed = 0;
        errorsAtStart = 0;
        waitCnt = 0;
        while (rstN !== 1'b1 && waitCnt < 20) begin
            @(negedge clock);
            waitCnt++;
        end
        if (rstN !== 1'b1) begin
            $display("timeout: reset was never released");
            errors++;
        end
        hostMemTest();
        aluTest();
        immTest();
        branchTest();
        contentionTest();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 testsRun, testsFailed, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* files.f */
logic/vsaIsaPkg.sv
logic/vsaBusPkg.sv
logic/vsaCore.sv
logic/memArbiter.sv
logic/sharedRam.sv
logic/apbHostPort.sv
logic/vsaTop.sv
tb/tbClock.sv
tb/vsaTb.sv

/* run.sh */
#!/usr/bin/env bash
# build with Verilator, run, and decide from the simulation log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f files.f --top-module vsaTb -o vsaSim
./obj_dir/vsaSim | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"
